// File: tone_table.svh
/* Phase step lookup for the base octave, included inside a module
   after the package import */

`ifndef TONE_TABLE_SVH
`define TONE_TABLE_SVH

// Steps are f * 2^24 / fs with fs = 50 MHz / 1024, octave 0 starting at C0
function automatic logic [PHASE_W-1:0] tone_step(input note_e note);
    logic [PHASE_W-1:0] step;
    case (note)
        NOTE_C:  step = PHASE_W'(5618);  // 16.35 Hz
        NOTE_CS: step = PHASE_W'(5952);
        NOTE_D:  step = PHASE_W'(6306);
        NOTE_DS: step = PHASE_W'(6681);
        NOTE_E:  step = PHASE_W'(7079);
        NOTE_F:  step = PHASE_W'(7500);
        NOTE_FS: step = PHASE_W'(7946);
        NOTE_G:  step = PHASE_W'(8418);
        NOTE_GS: step = PHASE_W'(8919);
        NOTE_A:  step = PHASE_W'(9449);  // 27.5 Hz, A4 is this shifted by 4
        NOTE_AS: step = PHASE_W'(10011);
        NOTE_B:  step = PHASE_W'(10606);
        default: step = '0;              // NOTE_OFF and unused codes hold the phase
    endcase
    return step;
endfunction

`endif

// File: audio_pkg.sv
/* Shared widths, note and mixer mode enums, and the I2S divider bit
   positions derived from the system clock rate */

`default_nettype none

package audio_pkg;

    localparam int PHASE_W  = 24; // Phase accumulator width of each voice
    localparam int OCTAVE_W = 3;  // Octaves 0 to 7

    // Chromatic notes of one octave, NOTE_OFF silences a voice
    typedef enum logic [3:0]
    {
        NOTE_OFF,
        NOTE_C,
        NOTE_CS,
        NOTE_D,
        NOTE_DS,
        NOTE_E,
        NOTE_F,
        NOTE_FS,
        NOTE_G,
        NOTE_GS,
        NOTE_A,
        NOTE_AS,
        NOTE_B
    } note_e;

    typedef enum logic [1:0]
    {
        MIX_STEREO, // Voice a on the left, voice b on the right
        MIX_MONO,   // Clipped sum of both voices on both channels
        MIX_MUTE    // Silence on both channels
    } mix_mode_e;

    // Divider bit that sets MCLK, keeping MCLK:BCLK:LRCLK at 256:64:1
    function automatic int mclk_bit(input int clk_mhz);
        return $clog2(clk_mhz - 4) - 4;
    endfunction

    function automatic int bclk_bit(input int clk_mhz);
        return mclk_bit(clk_mhz) + 2; // BCLK runs four times slower than MCLK
    endfunction

    function automatic int lrclk_bit(input int clk_mhz);
        return bclk_bit(clk_mhz) + 6; // 64 BCLK periods per frame
    endfunction

endpackage

`default_nettype wire

// File: tone_if.sv
/* Voice interface joining one oscillator to the mixer and to the
   frame strobe of the serializer */

`timescale 1ns/1ps
`default_nettype none

interface tone_if
#(
    parameter int SAMPLE_W = 16
);
    import audio_pkg::*;

    note_e                      note;    // Note code, held by the top level
    logic [OCTAVE_W-1:0]        octave;  // Left shift applied to the base step
    logic                       advance; // One pulse per I2S frame
    logic signed [SAMPLE_W-1:0] sample;  // Square wave output of the voice

    // The oscillator steps on advance and produces the sample
    modport osc (input note, input octave, input advance, output sample);

    modport mix (input sample); // Mixer reads only the sample

    modport seq (output advance); // Serializer owns the frame strobe

endinterface

`default_nettype wire

// File: tone_osc.sv
/* Square wave oscillator for one voice, built on a phase
   accumulator that steps once per audio frame */

`timescale 1ns/1ps
`default_nettype none

module tone_osc
#(
    parameter int SAMPLE_W = 16
)
(
    input  wire logic clk,
    input  wire logic reset,
    tone_if.osc       voice
);
    import audio_pkg::*;

    `include "tone_table.svh"

    // Quarter of full scale, so the mono sum of two voices just reaches the rails
    localparam logic signed [SAMPLE_W-1:0] AMP = {2'b01, {(SAMPLE_W - 2){1'b0}}};

    logic [PHASE_W-1:0]         phase;
    logic [PHASE_W-1:0]         step;
    logic [PHASE_W-1:0]         phase_next;
    logic signed [SAMPLE_W-1:0] sample_q;

    always_comb
    begin
        step       = tone_step(voice.note) << voice.octave; // Each octave doubles the rate
        phase_next = phase + step;                          // Wraps modulo 2^PHASE_W
    end

    // Phase and sample move together, only on the frame strobe
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase    <= '0;
            sample_q <= '0;
        end
        else if (voice.advance)
        begin
            if (voice.note == NOTE_OFF)
            begin
                phase    <= '0; // A silenced voice restarts from phase zero
                sample_q <= '0;
            end
            else
            begin
                phase    <= phase_next;
                // Upper half of the phase circle gives the negative level
                sample_q <= phase_next[PHASE_W-1] ? -AMP : AMP;
            end
        end
    end

    assign voice.sample = sample_q; // Held steady for the whole frame

endmodule

`default_nettype wire

// File: channel_mixer.sv
/* Registered two-voice mixer with stereo, saturating mono and mute
   modes */

`timescale 1ns/1ps
`default_nettype none

module channel_mixer
#(
    parameter int SAMPLE_W = 16
)
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    tone_if.mix                             voice_a,
    tone_if.mix                             voice_b,
    input  wire audio_pkg::mix_mode_e       mix_mode,
    output logic signed [SAMPLE_W-1:0]      left,
    output logic signed [SAMPLE_W-1:0]      right
);
    import audio_pkg::*;

    // Largest and smallest values of the output sample
    localparam logic signed [SAMPLE_W-1:0] POS_FULL = {1'b0, {(SAMPLE_W - 1){1'b1}}};
    localparam logic signed [SAMPLE_W-1:0] NEG_FULL = {1'b1, {(SAMPLE_W - 1){1'b0}}};

    logic signed [SAMPLE_W:0]   sum;  // One guard bit above the sample width
    logic signed [SAMPLE_W-1:0] mono;

    always_comb
    begin
        // Sign-extending casts keep the addition exact
        sum = (SAMPLE_W + 1)'(voice_a.sample) + (SAMPLE_W + 1)'(voice_b.sample);

        // The two top bits differ only when the sum left the sample range
        if (sum[SAMPLE_W] != sum[SAMPLE_W-1])
            mono = sum[SAMPLE_W] ? NEG_FULL : POS_FULL;
        else
            mono = sum[SAMPLE_W-1:0];
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            left  <= '0;
            right <= '0;
        end
        else
        begin
            case (mix_mode)
                MIX_STEREO:
                begin
                    left  <= voice_a.sample;
                    right <= voice_b.sample;
                end
                MIX_MONO:
                begin
                    left  <= mono; // Same clipped sum on both channels
                    right <= mono;
                end
                default:
                begin
                    // Mute, and also the unused fourth mode code
                    left  <= '0;
                    right <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: i2s_audio_out.sv
/* I2S serializer with MCLK, BCLK and LRCLK division, separate left and
   right slot loads and the once-per-frame advance strobe */

`timescale 1ns/1ps
`default_nettype none

module i2s_audio_out
#(
    parameter int CLK_MHZ  = 50,
    parameter int SAMPLE_W = 16
)
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic signed [SAMPLE_W-1:0] left,
    input  wire logic signed [SAMPLE_W-1:0] right,
    tone_if.seq                             seq_a,
    tone_if.seq                             seq_b,
    output logic                            mclk,
    output logic                            bclk,
    output logic                            lrclk, // Low for left, high for right
    output logic                            sdata
);
    import audio_pkg::*;

    // Clock ratios stay 256:64:1 whatever the system clock rate
    localparam int MCLK_BIT  = mclk_bit(CLK_MHZ);
    localparam int BCLK_BIT  = bclk_bit(CLK_MHZ);
    localparam int LRCLK_BIT = lrclk_bit(CLK_MHZ);

    logic [LRCLK_BIT-1:0] clk_div; // One full count is one stereo frame
    logic [31:0]          shift;   // Slot shift register, MSB drives sdata
    logic                 bclk_end;
    logic                 slot_load;
    logic                 load_left;
    logic                 load_right;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            clk_div <= '0;
        else
            clk_div <= clk_div + 1'b1;
    end

    // Output clocks are plain divider bits
    if (MCLK_BIT > 0)
    begin : g_mclk_div
        assign mclk = clk_div[MCLK_BIT-1];
    end
    else
    begin : g_mclk_lsb
        assign mclk = clk_div[0]; // Slow clocks cannot divide any further
    end

    assign bclk  = clk_div[BCLK_BIT-1];
    assign lrclk = clk_div[LRCLK_BIT-1];
    assign sdata = shift[31];

    // Last clk of a BCLK period, just before the falling edge of BCLK
    assign bclk_end = (clk_div[BCLK_BIT-1:0] == {BCLK_BIT{1'b1}});

    // End of the first BCLK in either half, so the MSB follows LRCLK by one BCLK
    assign slot_load  = bclk_end && (clk_div[LRCLK_BIT-2:BCLK_BIT] == '0);
    assign load_left  = slot_load && !clk_div[LRCLK_BIT-1];
    assign load_right = slot_load &&  clk_div[LRCLK_BIT-1];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            shift <= '0;
        else if (load_left)
            shift <= 32'($unsigned(left)) << (32 - SAMPLE_W);  // Left justified in the slot
        else if (load_right)
            shift <= 32'($unsigned(right)) << (32 - SAMPLE_W);
        else if (bclk_end)
            shift <= shift << 1; // Zeros fill the unused low bits
    end

    // Both voices step on the left load, once per frame
    assign seq_a.advance = load_left;
    assign seq_b.advance = load_left;

endmodule

`default_nettype wire

// File: audio_synth_top.sv
/* Two-voice square wave synthesizer driving an I2S stereo DAC with
   two oscillators, a channel mixer and the serializer */

`timescale 1ns/1ps
`default_nettype none

module audio_synth_top
#(
    parameter int CLK_MHZ  = 50, // System clock rate in MHz
    parameter int SAMPLE_W = 16  // Audio sample width, at most 32
)
(
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire audio_pkg::note_e              note_a,
    input  wire audio_pkg::note_e              note_b,
    input  wire logic [audio_pkg::OCTAVE_W-1:0] octave_a,
    input  wire logic [audio_pkg::OCTAVE_W-1:0] octave_b,
    input  wire audio_pkg::mix_mode_e          mix_mode,
    output logic                               mclk,
    output logic                               bclk,
    output logic                               lrclk,
    output logic                               sdata
);

    logic signed [SAMPLE_W-1:0] left;  // Mixer output for the left slot
    logic signed [SAMPLE_W-1:0] right; // Mixer output for the right slot

    tone_if #(.SAMPLE_W(SAMPLE_W)) voice_a ();
    tone_if #(.SAMPLE_W(SAMPLE_W)) voice_b ();

    // Note and octave come straight from the pins
    assign voice_a.note   = note_a;
    assign voice_a.octave = octave_a;
    assign voice_b.note   = note_b;
    assign voice_b.octave = octave_b;

    tone_osc #(.SAMPLE_W(SAMPLE_W)) osc_a
    (
        .clk   (clk),
        .reset (reset),
        .voice (voice_a)
    );

    tone_osc #(.SAMPLE_W(SAMPLE_W)) osc_b
    (
        .clk   (clk),
        .reset (reset),
        .voice (voice_b)
    );

    channel_mixer #(.SAMPLE_W(SAMPLE_W)) channel_mixer_i
    (
        .clk      (clk),
        .reset    (reset),
        .voice_a  (voice_a),
        .voice_b  (voice_b),
        .mix_mode (mix_mode),
        .left     (left),
        .right    (right)
    );

    // The serializer also produces the frame strobe for both voices
    i2s_audio_out
    #(
        .CLK_MHZ  (CLK_MHZ),
        .SAMPLE_W (SAMPLE_W)
    )
    i2s_audio_out_i
    (
        .clk   (clk),
        .reset (reset),
        .left  (left),
        .right (right),
        .seq_a (voice_a),
        .seq_b (voice_b),
        .mclk  (mclk),
        .bclk  (bclk),
        .lrclk (lrclk),
        .sdata (sdata)
    );

endmodule

`default_nettype wire

// File: tb_clock.sv
/* Testbench clock and power-on reset */

`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk; // 50 MHz at the default period
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0; // Released on a rising edge like the other stimulus
    end

endmodule

`default_nettype wire

// File: audio_synth_tb.sv
/* Directed tests of the two-voice synthesizer with an I2S decoder on
   the DAC pins and a reference square wave model */

`timescale 1ns/1ps
`default_nettype none

module audio_synth_tb;
    import audio_pkg::*;

    // The RTL include already set the guard, so clear it and take the table here too
    `undef TONE_TABLE_SVH
    `include "tone_table.svh"

    localparam int SAMPLE_W       = 16;                      // DUT default width
    localparam int AMP            = 2 ** (SAMPLE_W - 2);     // Level of one voice
    localparam int POS_FULL       = 2 ** (SAMPLE_W - 1) - 1;
    localparam int NEG_FULL       = -(2 ** (SAMPLE_W - 1));
    localparam int FRAME_CLKS     = 1024;                    // LRCLK period at 50 MHz
    localparam int BCLK_PER_FRAME = 64;
    localparam int MCLK_PER_FRAME = 256;
    localparam logic [31:0] LOW_MASK = 32'hFFFF_FFFF >> SAMPLE_W; // Slot bits below the sample
    // About 338 frames of tests at 1024 cycles each, with some margin on top
    localparam int TIMEOUT_CYCLES = 400000;

    logic                clk;
    logic                start_reset; // Power-on reset from the clock module
    logic                test_reset;  // Reset pulse at the start of each test
    logic                reset;
    note_e               note_a;
    note_e               note_b;
    logic [OCTAVE_W-1:0] octave_a;
    logic [OCTAVE_W-1:0] octave_b;
    mix_mode_e           mix_mode;
    logic                mclk;
    logic                bclk;
    logic                lrclk;
    logic                sdata;
    logic                bclk_seen;       // BCLK level at the previous falling clk edge
    int                  errors      = 0;
    int                  checks      = 0;
    int                  cycle_count = 0;

    tb_clock tb_clock_i (.clk (clk), .reset (start_reset));

    assign reset = start_reset || test_reset;

    audio_synth_top audio_synth_top_i
    (
        .clk      (clk),
        .reset    (reset),
        .note_a   (note_a),
        .note_b   (note_b),
        .octave_a (octave_a),
        .octave_b (octave_b),
        .mix_mode (mix_mode),
        .mclk     (mclk),
        .bclk     (bclk),
        .lrclk    (lrclk),
        .sdata    (sdata)
    );

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d clk cycles, the tests did not finish", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Square wave level of one voice at a given phase
    function automatic int voice_level(input note_e note, input logic [PHASE_W-1:0] phase);
        if (note == NOTE_OFF)
            return 0;
        return phase[PHASE_W-1] ? -AMP : AMP; // Upper half of the circle is negative
    endfunction

    // Half circles the phase passes between two step counts, each one flips the square wave
    function automatic int half_turns(input logic [PHASE_W-1:0] step, input int first,
                                      input int last);
        return int'((longint'(last) * step >> (PHASE_W - 1))
                  - (longint'(first) * step >> (PHASE_W - 1)));
    endfunction

    // Channel value of one slot, with the mono sum clipped to the sample range
    function automatic int mix_level(input mix_mode_e mode, input int a, input int b,
                                     input logic is_left);
        int level;
        case (mode)
            MIX_STEREO: level = is_left ? a : b;
            MIX_MONO:   level = (a + b > POS_FULL) ? POS_FULL :
                                (a + b < NEG_FULL) ? NEG_FULL : a + b;
            default:    level = 0;
        endcase
        return level;
    endfunction

    function automatic logic [31:0] slot_word(input int level);
        return 32'(level) << (32 - SAMPLE_W); // Sample sits at the top of the slot
    endfunction

    function automatic int slot_level(input logic [31:0] word);
        return int'($signed(word[31 -: SAMPLE_W]));
    endfunction

    // Holds the DUT in reset while the new inputs settle
    task automatic apply_reset(input note_e na, input logic [OCTAVE_W-1:0] oa, input note_e nb,
                               input logic [OCTAVE_W-1:0] ob, input mix_mode_e mode);
        @(posedge clk);
        test_reset <= 1'b1;
        note_a     <= na;
        octave_a   <= oa;
        note_b     <= nb;
        octave_b   <= ob;
        mix_mode   <= mode;
        repeat (2) @(posedge clk);
        test_reset <= 1'b0;
        bclk_seen  = 1'b0; // BCLK is low in reset
    endtask

    // Waits for the next rising BCLK and returns sdata and lrclk there
    task automatic next_bit(output logic bit_val, output logic lr_val);
        logic found;
        found = 1'b0;
        while (!found)
        begin
            @(negedge clk);
            found     = bclk && !bclk_seen;
            bclk_seen = bclk;
        end
        bit_val = sdata;
        lr_val  = lrclk;
    endtask

    // One stereo frame, the LSB of each slot arrives after the next LRCLK edge
    task automatic read_frame(output logic [31:0] left_word, output logic [31:0] right_word);
        logic b;
        logic lr;
        left_word  = '0;
        right_word = '0;
        for (int i = 0; i < 64; i++)
        begin
            next_bit(b, lr);
            checks++;
            if (lr !== ((i >= 31) && (i < 63)))
            begin
                errors++;
                $display("LRCLK is out of step with serial bit %0d of the frame", i);
            end
            if (i < 32)
                left_word = {left_word[30:0], b};
            else
                right_word = {right_word[30:0], b};
        end
    endtask

    // Decodes frames after reset and compares them with the model, counting sign flips
    task automatic run_frames(input string name, input int frames, input note_e na,
                              input logic [OCTAVE_W-1:0] oa, input note_e nb,
                              input logic [OCTAVE_W-1:0] ob, input mix_mode_e mode,
                              output int flips_l, output int flips_r);
        logic [PHASE_W-1:0] phase_a;
        logic [PHASE_W-1:0] phase_b;
        logic [PHASE_W-1:0] step_a;
        logic [PHASE_W-1:0] step_b;
        logic [31:0]        got_l;
        logic [31:0]        got_r;
        logic [31:0]        want_l;
        logic [31:0]        want_r;
        logic               b;
        logic               lr;
        int                 level_a;
        int                 level_b;
        int                 prev_a;
        int                 prev_b;
        int                 last_l;
        int                 last_r;
        apply_reset(na, oa, nb, ob, mode);
        step_a  = tone_step(na) << oa; // Each octave doubles the step
        step_b  = tone_step(nb) << ob;
        phase_a = '0;
        phase_b = '0;
        level_a = 0;
        level_b = 0;
        last_l  = 0;
        last_r  = 0;
        flips_l = 0;
        flips_r = 0;
        next_bit(b, lr); // First BCLK after reset carries no slot data
        for (int n = 1; n <= frames; n++)
        begin
            prev_a  = level_a; // Left slot is loaded before the voices step
            prev_b  = level_b;
            phase_a = phase_a + step_a;
            phase_b = phase_b + step_b;
            level_a = voice_level(na, phase_a);
            level_b = voice_level(nb, phase_b);
            want_l  = slot_word(mix_level(mode, prev_a, prev_b, 1'b1));
            want_r  = slot_word(mix_level(mode, level_a, level_b, 1'b0));
            read_frame(got_l, got_r);
            checks += 3;
            if (got_l !== want_l)
            begin
                errors++;
                $display("MISMATCH %s frame %0d left: expected %h, actual %h",
                         name, n, want_l, got_l);
            end
            if (got_r !== want_r)
            begin
                errors++;
                $display("MISMATCH %s frame %0d right: expected %h, actual %h",
                         name, n, want_r, got_r);
            end
            if (((got_l | got_r) & LOW_MASK) != 0)
            begin
                errors++;
                $display("MISMATCH %s frame %0d low slot bits: expected 0, actual %h",
                         name, n, (got_l | got_r) & LOW_MASK);
            end
            if (slot_level(got_l) != 0 && last_l != 0 && slot_level(got_l) != last_l)
                flips_l++;
            if (slot_level(got_r) != 0 && last_r != 0 && slot_level(got_r) != last_r)
                flips_r++;
            last_l = slot_level(got_l);
            last_r = slot_level(got_r);
        end
    endtask

    task automatic test_reset_timing();
        int   cycles;
        int   bclk_rises;
        int   mclk_rises;
        logic lr_last;
        logic bclk_last;
        logic mclk_last;
        apply_reset(NOTE_A, 3'd4, NOTE_C, 3'd5, MIX_STEREO);
        @(negedge clk);
        checks += 2;
        if (sdata !== 1'b0)
        begin
            errors++;
            $display("MISMATCH reset_timing sdata: expected 0, actual %b", sdata);
        end
        if (lrclk !== 1'b0)
        begin
            errors++;
            $display("MISMATCH reset_timing lrclk: expected 0, actual %b", lrclk);
        end
        do
        begin
            lr_last = lrclk;
            @(negedge clk);
        end while (!(lrclk && !lr_last));
        cycles     = 0;
        bclk_rises = 0;
        mclk_rises = 0;
        // One full LRCLK period from rising edge to rising edge
        do
        begin
            lr_last   = lrclk;
            bclk_last = bclk;
            mclk_last = mclk;
            @(negedge clk);
            cycles++;
            bclk_rises += int'(bclk && !bclk_last);
            mclk_rises += int'(mclk && !mclk_last);
        end while (!(lrclk && !lr_last));
        checks += 3;
        if (cycles != FRAME_CLKS)
        begin
            errors++;
            $display("MISMATCH reset_timing lrclk period: expected %0d, actual %0d",
                     FRAME_CLKS, cycles);
        end
        if (bclk_rises != BCLK_PER_FRAME)
        begin
            errors++;
            $display("MISMATCH reset_timing bclk per frame: expected %0d, actual %0d",
                     BCLK_PER_FRAME, bclk_rises);
        end
        if (mclk_rises != MCLK_PER_FRAME)
        begin
            errors++;
            $display("MISMATCH reset_timing mclk per frame: expected %0d, actual %0d",
                     MCLK_PER_FRAME, mclk_rises);
        end
    endtask

    task automatic test_stereo();
        int flips_l;
        int flips_r;
        run_frames("stereo", 40, NOTE_A, 3'd4, NOTE_C, 3'd5, MIX_STEREO, flips_l, flips_r);
    endtask

    // Octave 3 on the left, octave 4 on the right, long enough for several flips
    task automatic test_octave();
        int flips_l;
        int flips_r;
        int want_l;
        int want_r;
        run_frames("octave", 200, NOTE_B, 3'd3, NOTE_B, 3'd4, MIX_STEREO, flips_l, flips_r);
        // Left slots show the voice one step behind the right slots
        want_l = half_turns(tone_step(NOTE_B) << 3, 1, 199);
        want_r = half_turns(tone_step(NOTE_B) << 4, 1, 200);
        checks += 2;
        if (flips_l != want_l)
        begin
            errors++;
            $display("MISMATCH octave left flips: expected %0d, actual %0d", want_l, flips_l);
        end
        if (flips_r != want_r)
        begin
            errors++;
            $display("MISMATCH octave right flips: expected %0d, actual %0d", want_r, flips_r);
        end
    endtask

    task automatic test_mono_saturation();
        int flips_l;
        int flips_r;
        run_frames("mono", 40, NOTE_B, 3'd7, NOTE_B, 3'd7, MIX_MONO, flips_l, flips_r);
        checks++;
        if (flips_r == 0)
        begin
            errors++;
            $display("Mono test never saw both rail levels on the right slot");
        end
    endtask

    task automatic test_mute_and_off();
        int flips_l;
        int flips_r;
        run_frames("mute", 16, NOTE_B, 3'd7, NOTE_A, 3'd7, MIX_MUTE, flips_l, flips_r);
        run_frames("note_off", 40, NOTE_B, 3'd7, NOTE_OFF, 3'd7, MIX_STEREO, flips_l, flips_r);
        checks++;
        if (flips_l == 0)
        begin
            errors++;
            $display("Left voice stopped moving while the right voice was off");
        end
    endtask

    initial
    begin
        test_reset <= 1'b0;
        note_a     <= NOTE_OFF;
        note_b     <= NOTE_OFF;
        octave_a   <= '0;
        octave_b   <= '0;
        mix_mode   <= MIX_STEREO;
        bclk_seen  = 1'b0;
        @(negedge start_reset);
        test_reset_timing();
        test_stereo();
        test_octave();
        test_mono_saturation();
        test_mute_and_off();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
audio_pkg.sv
tone_if.sv
tone_osc.sv
channel_mixer.sv
i2s_audio_out.sv
audio_synth_top.sv
tb_clock.sv
audio_synth_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module audio_synth_tb -f sim.f -o audio_synth_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/audio_synth_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
